// File: build.f
+incdir+logic
logic/ffu_pkg.sv
logic/ffu_frf.sv
logic/ffu_vis.sv
logic/ffu_fsr.sv
logic/ffu_ctl.sv
logic/ffu_top.sv
verification/ffu_checker.sv
verification/ffu_tb.sv

// File: logic/ffu_ctl.sv
/* Control for the FP frontend: decode, two pipeline stages, pending table,
   write-port arbitration, and the store and FPU request outputs. */

`timescale 1ns/10ps
`include "ffu_defs.svh"

module ffu_ctl (
   input  logic                         rclk,
   input  logic                         rst,
   input  logic                         inst_vld,
   input  ffu_pkg::ffu_inst_t           inst,
   input  logic                         ld_vld,
   input  logic [`FFU_TID_W-1:0]        ld_tid,
   input  logic [`FFU_DWORD_W-1:0]      ld_data,
   input  logic                         cpx_vld,
   input  ffu_pkg::ffu_cpx_t            cpx,
   input  logic [`FFU_DWORD_W-1:0]      rs1_data,
   input  logic [`FFU_DWORD_W-1:0]      rs2_data,
   input  logic [`FFU_DWORD_W-1:0]      vis_result,
   input  ffu_pkg::ffu_fsr_t            fsr_rd,
   output logic [`FFU_TID_W-1:0]        rd_tid,
   output logic [`FFU_REG_W-2:0]        rs1_addr,
   output logic [`FFU_REG_W-2:0]        rs2_addr,
   output ffu_pkg::ffu_wr_t             frf_wr,
   output logic                         vis_vld,
   output ffu_pkg::ffu_vis_op_t         vis_op,
   output logic [`FFU_TID_W-1:0]        fsr_tid,
   output logic                         fsr_ld_vld,
   output ffu_pkg::ffu_fsr_t            fsr_ld_value,
   output logic                         fsr_exc_vld,
   output logic                         fsr_fcc_vld,
   output logic [`FFU_EXC_W-1:0]        fsr_exc,
   output logic [1:0]                   fsr_fcc,
   output logic                         st_vld,
   output logic [`FFU_DWORD_W-1:0]      st_data,
   output logic                         fpop_req_vld,
   output ffu_pkg::ffu_fpop_req_t       fpop_req
);

   typedef enum logic [1:0] {pend_single, pend_double, pend_fsr} pend_kind_t;

   typedef struct packed {
      logic                    vld;
      pend_kind_t              kind;
      logic [`FFU_REG_W-1:0]   rd;
   } pend_ent_t;

   pend_ent_t                 pend [`FFU_NUM_THREADS];
   pend_ent_t                 ld_ent, cpx_ent;
   ffu_pkg::ffu_inst_t        s1_inst;
   logic                      s1_vld;
   logic                      s2_vis_vld;
   logic [`FFU_TID_W-1:0]     s2_tid;
   logic [`FFU_REG_W-1:0]     s2_rd;
   logic                      new_pend, pend_busy;
   logic                      ld_hit, ld_frf, ld_fsr, cpx_hit, cpx_frf;

   ////////////////////////////////////////
   // Decode and read addresses, cycle 0
   ////////////////////////////////////////
   assign rd_tid   = inst.tid;
   assign rs1_addr = inst.rs1[`FFU_REG_W-1:1];
   assign rs2_addr = (inst.op == ffu_pkg::op_fst) ? inst.rd[`FFU_REG_W-1:1]   // Store source
                                                  : inst.rs2[`FFU_REG_W-1:1];
   assign new_pend = inst_vld && (inst.op inside {ffu_pkg::op_fld, ffu_pkg::op_ldfsr,
                                                  ffu_pkg::op_fpop});

   always_ff @(posedge rclk) begin
      if (rst) begin
         s1_vld     <= 1'b0;
         s2_vis_vld <= 1'b0;
      end else begin
         s1_vld     <= inst_vld;
         s2_vis_vld <= vis_vld;
      end
   end

   always_ff @(posedge rclk) begin
      s1_inst <= inst;
      s2_tid  <= s1_inst.tid;                   // VIS write-back target
      s2_rd   <= s1_inst.rd;
   end

   assign vis_vld = s1_vld && (s1_inst.op == ffu_pkg::op_vis);
   assign vis_op  = ffu_pkg::ffu_vis_op_t'(s1_inst.func[2:0]);

   ////////////////////////////////////////
   // Pending table
   ////////////////////////////////////////
   assign ld_ent  = pend[ld_tid];
   assign cpx_ent = pend[cpx.tid];
   assign ld_hit  = ld_vld && ld_ent.vld;
   assign ld_frf  = ld_hit && (ld_ent.kind != pend_fsr);
   assign ld_fsr  = ld_hit && (ld_ent.kind == pend_fsr);
   assign cpx_hit = cpx_vld && cpx_ent.vld;
   assign cpx_frf = cpx_hit && !cpx.fcmp;

   always_ff @(posedge rclk) begin
      if (rst) begin
         for (int t = 0; t < `FFU_NUM_THREADS; t++) begin
            pend[t] <= '0;
         end
      end else begin
         if (ld_hit) pend[ld_tid].vld <= 1'b0;
         if (cpx_hit) pend[cpx.tid].vld <= 1'b0;
         if (new_pend) begin                    // Set wins over a same-cycle retire
            pend[inst.tid].vld  <= 1'b1;
            pend[inst.tid].rd   <= inst.rd;
            pend[inst.tid].kind <= (inst.op == ffu_pkg::op_ldfsr) ? pend_fsr :
                                   (inst.op == ffu_pkg::op_fld && inst.single) ? pend_single :
                                   pend_double;
         end
      end
   end

   ////////////////////////////////////////
   // Write port and FSR strobes
   ////////////////////////////////////////
   always_comb begin
      frf_wr = '0;
      if (s2_vis_vld) begin
         frf_wr = '{wen: 2'b11, tid: s2_tid, addr: s2_rd[`FFU_REG_W-1:1], data: vis_result};
      end else if (ld_frf) begin
         frf_wr.tid  = ld_tid;
         frf_wr.addr = ld_ent.rd[`FFU_REG_W-1:1];
         if (ld_ent.kind == pend_single) begin
            frf_wr.wen  = ld_ent.rd[0] ? 2'b01 : 2'b10;   // Odd register is the low word
            frf_wr.data = {2{ld_data[`FFU_WORD_W-1:0]}};
         end else begin
            frf_wr.wen  = 2'b11;
            frf_wr.data = ld_data;
         end
      end else if (cpx_frf) begin
         frf_wr = '{wen: 2'b11, tid: cpx.tid, addr: cpx_ent.rd[`FFU_REG_W-1:1], data: cpx.data};
      end
   end

   always_comb begin
      fsr_ld_value = ffu_pkg::ffu_fsr_t'(ld_data[`FFU_WORD_W-1:0]);
      fsr_ld_value.rsvd_29_28 = '0;
      fsr_ld_value.rsvd_22_12 = '0;
   end

   assign fsr_ld_vld  = ld_fsr;
   assign fsr_exc_vld = cpx_frf;
   assign fsr_fcc_vld = cpx_hit && cpx.fcmp;
   assign fsr_exc     = cpx.exc;
   assign fsr_fcc     = cpx.fcc;
   // Updates own the FSR port, otherwise stfsr reads its thread
   assign fsr_tid     = ld_fsr ? ld_tid : cpx_hit ? cpx.tid : s1_inst.tid;

   ////////////////////////////////////////
   // Output strobes, cycle 2
   ////////////////////////////////////////
   always_ff @(posedge rclk) begin
      if (rst) begin
         st_vld       <= 1'b0;
         fpop_req_vld <= 1'b0;
      end else begin
         st_vld       <= s1_vld && (s1_inst.op inside {ffu_pkg::op_fst, ffu_pkg::op_stfsr});
         fpop_req_vld <= s1_vld && (s1_inst.op == ffu_pkg::op_fpop);
      end
   end

   always_ff @(posedge rclk) begin
      if (s1_inst.op == ffu_pkg::op_stfsr) begin
         st_data <= {{`FFU_WORD_W{1'b0}}, fsr_rd};
      end else if (s1_inst.single) begin
         st_data <= {{`FFU_WORD_W{1'b0}}, s1_inst.rd[0] ? rs2_data[`FFU_WORD_W-1:0]
                                        : rs2_data[`FFU_DWORD_W-1:`FFU_WORD_W]};
      end else begin
         st_data <= rs2_data;
      end
      fpop_req <= '{tid: s1_inst.tid, func: s1_inst.func, rs1: rs1_data, rs2: rs2_data};
   end

   assign pend_busy = pend[inst.tid].vld &&
                      !(ld_hit && ld_tid == inst.tid) && !(cpx_hit && cpx.tid == inst.tid);

   // One outstanding load or FPU op per thread
   a_one_pend: assert property (@(posedge rclk) disable iff (rst) new_pend |-> !pend_busy)
      else $error("New pending entry for a thread that is still pending");

   // Returns and the VIS write-back share one write port
   a_no_wr_clash: assert property (@(posedge rclk) disable iff (rst)
      $onehot0({s2_vis_vld, ld_hit, cpx_hit}))
      else $error("Write-port collision between VIS, load and FPU return");

endmodule

// File: logic/ffu_defs.svh
/* Size macros for the FP frontend.
   Include wherever a width or a count is needed. */

`ifndef FFU_DEFS_SVH
`define FFU_DEFS_SVH

// Threads and register file
`define FFU_NUM_THREADS 4
`define FFU_TID_W       2
`define FFU_NUM_DREGS   16
`define FFU_REG_W       5

// Data widths
`define FFU_WORD_W      32
`define FFU_DWORD_W     64

// FSR and function fields
`define FFU_EXC_W       5
`define FFU_FUNC_W      4

`endif

// File: logic/ffu_frf.sv
/* Per-thread FP register file of 64-bit doubles.
   Two registered read ports, one write port with separate word enables. */

`timescale 1ns/10ps
`include "ffu_defs.svh"

module ffu_frf (
   input  logic                         rclk,
   input  logic [`FFU_TID_W-1:0]        rd_tid,
   input  logic [`FFU_REG_W-2:0]        rs1_addr,
   input  logic [`FFU_REG_W-2:0]        rs2_addr,
   input  ffu_pkg::ffu_wr_t             frf_wr,
   output logic [`FFU_DWORD_W-1:0]      rs1_data,
   output logic [`FFU_DWORD_W-1:0]      rs2_data
);

   localparam int DEPTH = `FFU_NUM_THREADS * `FFU_NUM_DREGS;

   logic [`FFU_DWORD_W-1:0] mem [DEPTH];
   logic [`FFU_TID_W+`FFU_REG_W-2:0] wr_idx;

   assign wr_idx = {frf_wr.tid, frf_wr.addr};   // Thread picks the bank

   ////////////////////////////////////////
   // Write port
   ////////////////////////////////////////
   always_ff @(posedge rclk) begin
      if (frf_wr.wen[1]) begin
         mem[wr_idx][`FFU_DWORD_W-1:`FFU_WORD_W] <= frf_wr.data[`FFU_DWORD_W-1:`FFU_WORD_W];
      end
      if (frf_wr.wen[0]) begin
         mem[wr_idx][`FFU_WORD_W-1:0] <= frf_wr.data[`FFU_WORD_W-1:0];
      end
   end

   ////////////////////////////////////////
   // Read ports
   ////////////////////////////////////////
   always_ff @(posedge rclk) begin
      rs1_data <= mem[{rd_tid, rs1_addr}];      // Old data on same-edge write
      rs2_data <= mem[{rd_tid, rs2_addr}];
   end

endmodule

// File: logic/ffu_fsr.sv
/* The four per-thread FSRs.
   Updated at the clock edge from the control strobes, read combinationally. */

`timescale 1ns/10ps
`include "ffu_defs.svh"

module ffu_fsr (
   input  logic                         rclk,
   input  logic                         rst,
   input  logic [`FFU_TID_W-1:0]        fsr_tid,
   input  logic                         fsr_ld_vld,
   input  ffu_pkg::ffu_fsr_t            fsr_ld_value,
   input  logic                         fsr_exc_vld,
   input  logic [`FFU_EXC_W-1:0]        fsr_exc,
   input  logic                         fsr_fcc_vld,
   input  logic [1:0]                   fsr_fcc,
   output ffu_pkg::ffu_fsr_t            fsr_rd
);

   ffu_pkg::ffu_fsr_t fsr_q [`FFU_NUM_THREADS];

   always_ff @(posedge rclk) begin
      if (rst) begin
         for (int t = 0; t < `FFU_NUM_THREADS; t++) begin
            fsr_q[t] <= '0;
         end
      end else if (fsr_ld_vld) begin
         fsr_q[fsr_tid] <= fsr_ld_value;        // Whole-register replace
      end else begin
         if (fsr_exc_vld) begin
            fsr_q[fsr_tid].cexc <= fsr_exc;
            fsr_q[fsr_tid].aexc <= fsr_q[fsr_tid].aexc | fsr_exc;   // Sticky
         end
         if (fsr_fcc_vld) begin
            fsr_q[fsr_tid].fcc0 <= fsr_fcc;
         end
      end
   end

   assign fsr_rd = fsr_q[fsr_tid];

   // Control never loads an FSR while an FPU return updates it
   a_no_ld_upd: assert property (@(posedge rclk) disable iff (rst)
      fsr_ld_vld |-> !(fsr_exc_vld || fsr_fcc_vld))
      else $error("FSR load coincides with an exception or fcc update");

endmodule

// File: logic/ffu_pkg.sv
/* Types shared by the FP frontend modules and its testbench.
   Referenced by scoped name, e.g. ffu_pkg::ffu_inst_t. */

`include "ffu_defs.svh"

package ffu_pkg;

   typedef enum logic [2:0] {
      op_fld, op_fst, op_ldfsr, op_stfsr, op_vis, op_fpop
   } ffu_op_t;

   typedef enum logic [2:0] {
      vis_padd16, vis_padd32, vis_psub16, vis_psub32,
      vis_and, vis_or, vis_xor, vis_nor
   } ffu_vis_op_t;

   typedef struct packed {
      ffu_op_t                 op;
      logic [`FFU_TID_W-1:0]   tid;
      logic [`FFU_REG_W-1:0]   rs1;
      logic [`FFU_REG_W-1:0]   rs2;
      logic [`FFU_REG_W-1:0]   rd;          // Also the store source
      logic                    single;
      logic [`FFU_FUNC_W-1:0]  func;
   } ffu_inst_t;

   typedef struct packed {
      logic [1:0]                 wen;      // [1] upper word, [0] lower word
      logic [`FFU_TID_W-1:0]      tid;
      logic [`FFU_REG_W-2:0]      addr;
      logic [`FFU_DWORD_W-1:0]    data;
   } ffu_wr_t;

   typedef struct packed {
      logic [1:0]               rd;         // Rounding direction
      logic [1:0]               rsvd_29_28;
      logic [`FFU_EXC_W-1:0]    tem;
      logic [10:0]              rsvd_22_12;
      logic [1:0]               fcc0;
      logic [`FFU_EXC_W-1:0]    aexc;
      logic [`FFU_EXC_W-1:0]    cexc;
   } ffu_fsr_t;

   typedef struct packed {
      logic [`FFU_TID_W-1:0]      tid;
      logic [`FFU_FUNC_W-1:0]     func;
      logic [`FFU_DWORD_W-1:0]    rs1;
      logic [`FFU_DWORD_W-1:0]    rs2;
   } ffu_fpop_req_t;

   typedef struct packed {
      logic [`FFU_TID_W-1:0]      tid;
      logic [`FFU_DWORD_W-1:0]    data;
      logic                       fcmp;     // Compare result, only fcc valid
      logic [1:0]                 fcc;
      logic [`FFU_EXC_W-1:0]      exc;
   } ffu_cpx_t;

endpackage

// File: logic/ffu_top.sv
/* Top level of the FP frontend.
   Connects control, FSRs, register file and VIS unit. */

`timescale 1ns/10ps
`include "ffu_defs.svh"

module ffu_top (
   input  logic                         rclk,
   input  logic                         rst,
   input  logic                         inst_vld,
   input  ffu_pkg::ffu_inst_t           inst,
   input  logic                         ld_vld,
   input  logic [`FFU_TID_W-1:0]        ld_tid,
   input  logic [`FFU_DWORD_W-1:0]      ld_data,
   input  logic                         cpx_vld,
   input  ffu_pkg::ffu_cpx_t            cpx,
   output logic                         st_vld,
   output logic [`FFU_DWORD_W-1:0]      st_data,
   output logic                         fpop_req_vld,
   output ffu_pkg::ffu_fpop_req_t       fpop_req
);

   logic [`FFU_TID_W-1:0]     rd_tid, fsr_tid;
   logic [`FFU_REG_W-2:0]     rs1_addr, rs2_addr;
   logic [`FFU_DWORD_W-1:0]   rs1_data, rs2_data, vis_result;
   ffu_pkg::ffu_wr_t          frf_wr;
   logic                      vis_vld;
   ffu_pkg::ffu_vis_op_t      vis_op;
   ffu_pkg::ffu_fsr_t         fsr_rd, fsr_ld_value;
   logic                      fsr_ld_vld, fsr_exc_vld, fsr_fcc_vld;
   logic [`FFU_EXC_W-1:0]     fsr_exc;
   logic [1:0]                fsr_fcc;

   ffu_ctl ffu_ctl_inst (
      .rclk, .rst, .inst_vld, .inst, .ld_vld, .ld_tid, .ld_data, .cpx_vld, .cpx,
      .rs1_data, .rs2_data, .vis_result, .fsr_rd,
      .rd_tid, .rs1_addr, .rs2_addr, .frf_wr, .vis_vld, .vis_op,
      .fsr_tid, .fsr_ld_vld, .fsr_ld_value, .fsr_exc_vld, .fsr_fcc_vld, .fsr_exc, .fsr_fcc,
      .st_vld, .st_data, .fpop_req_vld, .fpop_req
   );

   ffu_fsr ffu_fsr_inst (
      .rclk, .rst, .fsr_tid, .fsr_ld_vld, .fsr_ld_value,
      .fsr_exc_vld, .fsr_exc, .fsr_fcc_vld, .fsr_fcc, .fsr_rd
   );

   ffu_frf ffu_frf_inst (
      .rclk, .rd_tid, .rs1_addr, .rs2_addr, .frf_wr, .rs1_data, .rs2_data
   );

   ffu_vis ffu_vis_inst (
      .rclk, .rst, .vis_vld, .vis_op, .rs1_data, .rs2_data, .vis_result
   );

endmodule

// File: logic/ffu_vis.sv
/* VIS partitioned add/subtract and logic unit.
   Operands arrive with vis_vld; the result is held until the next op. */

`timescale 1ns/10ps
`include "ffu_defs.svh"

module ffu_vis (
   input  logic                         rclk,
   input  logic                         rst,
   input  logic                         vis_vld,
   input  ffu_pkg::ffu_vis_op_t         vis_op,
   input  logic [`FFU_DWORD_W-1:0]      rs1_data,
   input  logic [`FFU_DWORD_W-1:0]      rs2_data,
   output logic [`FFU_DWORD_W-1:0]      vis_result
);

   logic                      sub;
   logic [`FFU_DWORD_W-1:0]   b_in;
   logic [`FFU_DWORD_W-1:0]   sum16;
   logic [`FFU_DWORD_W-1:0]   sum32;
   logic [`FFU_DWORD_W-1:0]   result;

   assign sub  = (vis_op == ffu_pkg::vis_psub16) || (vis_op == ffu_pkg::vis_psub32);
   assign b_in = sub ? ~rs2_data : rs2_data;    // Two's complement with the lane carry-in

   ////////////////////////////////////////
   // Partitioned adders
   ////////////////////////////////////////
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         sum16[i*16 +: 16] = rs1_data[i*16 +: 16] + b_in[i*16 +: 16] + 16'(sub);
      end
      for (int j = 0; j < 2; j++) begin
         sum32[j*32 +: 32] = rs1_data[j*32 +: 32] + b_in[j*32 +: 32] + 32'(sub);
      end
   end

   always_comb begin
      case (vis_op)
         ffu_pkg::vis_padd16, ffu_pkg::vis_psub16: result = sum16;
         ffu_pkg::vis_padd32, ffu_pkg::vis_psub32: result = sum32;
         ffu_pkg::vis_and:                         result = rs1_data & rs2_data;
         ffu_pkg::vis_or:                          result = rs1_data | rs2_data;
         ffu_pkg::vis_xor:                         result = rs1_data ^ rs2_data;
         default:                                  result = ~(rs1_data | rs2_data);
      endcase
   end

   ////////////////////////////////////////
   // Result register
   ////////////////////////////////////////
   always_ff @(posedge rclk) begin
      if (rst) begin
         vis_result <= '0;
      end else if (vis_vld) begin
         vis_result <= result;                  // Written back one cycle later
      end
   end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Compile and run the FP frontend testbench with Verilator.
# The result is decided by the pass line in the simulation log.

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --assert -Wno-fatal -f build.f --top-module ffu_tb -Mdir obj_dir; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/Vffu_tb > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "Testbench passed" "$log"; then
   exit 0
fi
exit 1

// File: verification/ffu_checker.sv
/* Watches the store and FPU request strobes of the DUT.
   Compares each one with the expectation queued by the testbench and keeps counts. */

`timescale 1ns/10ps
`include "ffu_defs.svh"

module ffu_checker (
   input  logic                         rclk,
   input  logic                         rst,
   input  logic                         st_vld,
   input  logic [`FFU_DWORD_W-1:0]      st_data,
   input  logic                         fpop_req_vld,
   input  ffu_pkg::ffu_fpop_req_t       fpop_req
);

   localparam int REQ_W = $bits(ffu_pkg::ffu_fpop_req_t);

   string               exp_name [$];
   logic                exp_is_req [$];            // 1 for an FPU request, 0 for a store
   logic [REQ_W-1:0]    exp_value [$];
   int                  checks = 0;
   int                  errors = 0;

   function automatic void expect_value(input string name, input logic is_req,
                                        input logic [REQ_W-1:0] value);
      exp_name.push_back(name);
      exp_is_req.push_back(is_req);
      exp_value.push_back(value);
   endfunction

   function automatic int unmatched_count();
      return exp_name.size();
   endfunction

   function automatic void report_counts();
      $display("Checks: %0d, errors: %0d, unmatched: %0d", checks, errors, exp_name.size());
   endfunction

   task automatic compare(input logic is_req, input logic [REQ_W-1:0] actual);
      string               name;
      logic                kind;
      logic [REQ_W-1:0]    value;
      checks++;
      if (exp_name.size() == 0) begin
         errors++;
         $display("Unexpected %s at %0t with no test waiting for it",
                  is_req ? "fpop_req_vld" : "st_vld", $time);
      end else begin
         name  = exp_name.pop_front();
         kind  = exp_is_req.pop_front();
         value = exp_value.pop_front();
         if (kind != is_req) begin
            errors++;
            $display("%s: got %s instead of %s", name, is_req ? "an FPU request" : "a store",
                     kind ? "an FPU request" : "a store");
         end else if (actual !== value) begin
            errors++;
            $display("[ERROR] %s expected %h actual %h", name, value, actual);
         end else begin
            $display("ok     %s", name);
         end
      end
   endtask

   ////////////////////////////////////////
   // Sample mid-cycle, away from the edge
   ////////////////////////////////////////
   always @(negedge rclk) begin
      if (!rst) begin
         if (st_vld) compare(1'b0, REQ_W'(st_data));
         if (fpop_req_vld) compare(1'b1, fpop_req);
      end
   end

endmodule

// File: verification/ffu_tb.sv
/* Testbench for the FP frontend, with its clock generator.
   Builds a table of steps, applies it to the DUT and keeps a reference model. */

`timescale 1ns/10ps
`include "ffu_defs.svh"

module ffu_clkgen (
   output logic rclk
);

   initial begin
      rclk = 1'b0;
      forever #10 rclk = ~rclk;                 // 20 ns period
   end

endmodule

module ffu_tb;

   localparam int REQ_W = $bits(ffu_pkg::ffu_fpop_req_t);

   typedef struct packed {
      ffu_pkg::ffu_inst_t         inst;
      logic [`FFU_DWORD_W-1:0]    ret_data;     // Load data or FPU result
      logic                       fcmp;
      logic [1:0]                 fcc;
      logic [`FFU_EXC_W-1:0]      exc;
   } step_t;

   logic                      rclk, rst, inst_vld, ld_vld, cpx_vld, st_vld, fpop_req_vld;
   ffu_pkg::ffu_inst_t        inst;
   logic [`FFU_TID_W-1:0]     ld_tid;
   logic [`FFU_DWORD_W-1:0]   ld_data, st_data;
   ffu_pkg::ffu_cpx_t         cpx;
   ffu_pkg::ffu_fpop_req_t    fpop_req;

   step_t                     steps [$];
   string                     names [$];
   logic [31:0]               lcg_state;
   logic                      timed_out;
   int                        timing_errors;
   logic [`FFU_DWORD_W-1:0]   model_frf [`FFU_NUM_THREADS][`FFU_NUM_DREGS];
   logic [`FFU_WORD_W-1:0]    model_fsr [`FFU_NUM_THREADS];

   ffu_clkgen clkgen_inst (.rclk);

   ffu_top ffu_top_inst (
      .rclk, .rst, .inst_vld, .inst, .ld_vld, .ld_tid, .ld_data, .cpx_vld, .cpx,
      .st_vld, .st_data, .fpop_req_vld, .fpop_req
   );

   ffu_checker checker_inst (.rclk, .rst, .st_vld, .st_data, .fpop_req_vld, .fpop_req);

   ////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////
   function automatic logic [63:0] rand_dword();
      logic [63:0] d;
      lcg_state  = lcg_state * 32'd1664525 + 32'd1013904223;
      d[63:32]   = lcg_state;
      lcg_state  = lcg_state * 32'd1664525 + 32'd1013904223;
      d[31:0]    = lcg_state;
      return d;
   endfunction

   // Lane-wise VIS reference, lanes wrap on their own width
   function automatic logic [63:0] vis_model(input ffu_pkg::ffu_vis_op_t op,
                                             input logic [63:0] a, input logic [63:0] b);
      logic [63:0] r, mask, la, lb;
      int          w;
      bit          sub;
      w    = (op == ffu_pkg::vis_padd32 || op == ffu_pkg::vis_psub32) ? 32 : 16;
      sub  = (op == ffu_pkg::vis_psub16 || op == ffu_pkg::vis_psub32);
      mask = (w == 32) ? 64'hFFFF_FFFF : 64'hFFFF;
      r    = '0;
      case (op)
         ffu_pkg::vis_and: r = a & b;
         ffu_pkg::vis_or:  r = a | b;
         ffu_pkg::vis_xor: r = a ^ b;
         ffu_pkg::vis_nor: r = ~(a | b);
         default: begin
            for (int lo = 0; lo < 64; lo += w) begin
               la = (a >> lo) & mask;
               lb = (b >> lo) & mask;
               r  = r | (((sub ? la - lb : la + lb) & mask) << lo);
            end
         end
      endcase
      return r;
   endfunction

   task automatic add_step(input string name, input ffu_pkg::ffu_op_t op, input int tid,
                           input int rd, input int rs1 = 0, input int rs2 = 0,
                           input bit single = 0, input int func = 0,
                           input logic [63:0] ret_data = '0, input bit fcmp = 0,
                           input int fcc = 0, input int exc = 0);
      step_t s;
      s.inst = '{op: op, tid: 2'(tid), rs1: 5'(rs1), rs2: 5'(rs2), rd: 5'(rd),
                 single: single, func: 4'(func)};
      s.ret_data = ret_data;
      s.fcmp     = fcmp;
      s.fcc      = 2'(fcc);
      s.exc      = 5'(exc);
      steps.push_back(s);
      names.push_back(name);
   endtask

   task automatic build_table();
      ffu_pkg::ffu_vis_op_t vop;
      for (int t = 0; t < `FFU_NUM_THREADS; t++) begin
         add_step($sformatf("stfsr_reset_t%0d", t), ffu_pkg::op_stfsr, t, 0);
      end
      // Loads and stores, same register number in two threads
      add_step("fld_d_t0", ffu_pkg::op_fld, 0, 4, 0, 0, 0, 0, rand_dword());
      add_step("fld_d_t1", ffu_pkg::op_fld, 1, 4, 0, 0, 0, 0, rand_dword());
      add_step("fst_d_t0", ffu_pkg::op_fst, 0, 4);
      add_step("fst_d_t1", ffu_pkg::op_fst, 1, 4);
      add_step("fld_s_lo_t0", ffu_pkg::op_fld, 0, 5, 0, 0, 1, 0, rand_dword());
      add_step("fst_d_after_lo_t0", ffu_pkg::op_fst, 0, 4);
      add_step("fst_s_lo_t0", ffu_pkg::op_fst, 0, 5, 0, 0, 1);
      add_step("fst_s_hi_t0", ffu_pkg::op_fst, 0, 4, 0, 0, 1);
      add_step("fld_s_hi_t1", ffu_pkg::op_fld, 1, 4, 0, 0, 1, 0, rand_dword());
      add_step("fst_d_after_hi_t1", ffu_pkg::op_fst, 1, 4);
      // VIS functions on random operands
      add_step("fld_vis_a_t2", ffu_pkg::op_fld, 2, 0, 0, 0, 0, 0, rand_dword());
      add_step("fld_vis_b_t2", ffu_pkg::op_fld, 2, 2, 0, 0, 0, 0, rand_dword());
      for (int f = 0; f < 8; f++) begin
         vop = ffu_pkg::ffu_vis_op_t'(f);
         add_step($sformatf("%s", vop.name()), ffu_pkg::op_vis, 2, 8, 0, 2, 0, f);
         add_step($sformatf("fst_%s", vop.name()), ffu_pkg::op_fst, 2, 8);
      end
      // FPU dispatch and write-back
      add_step("fld_fp_a_t3", ffu_pkg::op_fld, 3, 0, 0, 0, 0, 0, rand_dword());
      add_step("fld_fp_b_t3", ffu_pkg::op_fld, 3, 2, 0, 0, 0, 0, rand_dword());
      add_step("fpop_t3", ffu_pkg::op_fpop, 3, 6, 0, 2, 0, 5, rand_dword(), 0, 0, 5'b00001);
      add_step("fst_fpop_t3", ffu_pkg::op_fst, 3, 6);
      add_step("stfsr_fpop_t3", ffu_pkg::op_stfsr, 3, 0);
      // FSR load, compare and accrued exceptions
      add_step("ldfsr_t1", ffu_pkg::op_ldfsr, 1, 0, 0, 0, 0, 0, 64'h1234_5678_FFFF_FFFF);
      add_step("stfsr_ldfsr_t1", ffu_pkg::op_stfsr, 1, 0);
      add_step("fcmp_t1", ffu_pkg::op_fpop, 1, 12, 4, 4, 0, 9, rand_dword(), 1, 2'b01);
      add_step("stfsr_fcmp_t1", ffu_pkg::op_stfsr, 1, 0);
      add_step("fpop_exc1_t2", ffu_pkg::op_fpop, 2, 10, 0, 2, 0, 3, rand_dword(), 0, 0, 5'b00100);
      add_step("fpop_exc2_t2", ffu_pkg::op_fpop, 2, 10, 2, 0, 0, 7, rand_dword(), 0, 0, 5'b10010);
      add_step("stfsr_exc_t2", ffu_pkg::op_stfsr, 2, 0);
      add_step("fst_exc_t2", ffu_pkg::op_fst, 2, 10);
   endtask

   // Strobe is due in cycle 2, the second negedge after the issue edge
   task automatic wait_strobe(input string name, input logic is_req);
      int n;
      for (n = 0; n < 10; n++) begin
         @(negedge rclk);
         if (is_req ? fpop_req_vld : st_vld) break;
      end
      if (n == 10) begin
         $display("Timeout in %s: %s never came", name, is_req ? "fpop_req_vld" : "st_vld");
         timed_out = 1'b1;
      end else if (n != 1) begin
         $display("%s: %s came in cycle %0d instead of cycle 2", name,
                  is_req ? "fpop_req_vld" : "st_vld", n + 1);
         timing_errors++;
      end
   endtask

   ////////////////////////////////////////
   // Apply one step and track the model
   ////////////////////////////////////////
   task automatic apply_step(input step_t s, input string name);
      ffu_pkg::ffu_inst_t     in;
      logic [63:0]            src;
      logic [REQ_W-1:0]       exp;
      int                     lat;
      in  = s.inst;
      src = model_frf[in.tid][in.rd[4:1]];
      case (in.op)
         ffu_pkg::op_fst: begin
            exp = in.single ? REQ_W'(in.rd[0] ? src[31:0] : src[63:32]) : REQ_W'(src);
            checker_inst.expect_value(name, 1'b0, exp);
         end
         ffu_pkg::op_stfsr: checker_inst.expect_value(name, 1'b0, REQ_W'(model_fsr[in.tid]));
         ffu_pkg::op_fpop: begin
            exp = {in.tid, in.func, model_frf[in.tid][in.rs1[4:1]],
                   model_frf[in.tid][in.rs2[4:1]]};
            checker_inst.expect_value(name, 1'b1, exp);
         end
         ffu_pkg::op_vis: begin
            model_frf[in.tid][in.rd[4:1]] = vis_model(ffu_pkg::ffu_vis_op_t'(in.func[2:0]),
               model_frf[in.tid][in.rs1[4:1]], model_frf[in.tid][in.rs2[4:1]]);
         end
         default: ;
      endcase
      @(posedge rclk);
      #2;
      inst_vld = 1'b1;
      inst     = in;
      @(posedge rclk);
      #2;
      inst_vld = 1'b0;
      if (in.op inside {ffu_pkg::op_fst, ffu_pkg::op_stfsr}) wait_strobe(name, 1'b0);
      if (in.op == ffu_pkg::op_fpop) wait_strobe(name, 1'b1);
      if (!timed_out && in.op inside {ffu_pkg::op_fld, ffu_pkg::op_ldfsr, ffu_pkg::op_fpop}) begin
         lat = 1 + int'(rand_dword() % 4);      // Return latency of 1 to 4 cycles
         repeat (lat) @(posedge rclk);
         #2;
         if (in.op == ffu_pkg::op_fpop) begin
            cpx_vld = 1'b1;
            cpx     = '{tid: in.tid, data: s.ret_data, fcmp: s.fcmp, fcc: s.fcc, exc: s.exc};
         end else begin
            ld_vld  = 1'b1;
            ld_tid  = in.tid;
            ld_data = s.ret_data;
         end
         @(posedge rclk);
         #2;
         ld_vld  = 1'b0;
         cpx_vld = 1'b0;
         if (in.op == ffu_pkg::op_fld && !in.single) begin
            model_frf[in.tid][in.rd[4:1]] = s.ret_data;
         end else if (in.op == ffu_pkg::op_fld && in.rd[0]) begin
            model_frf[in.tid][in.rd[4:1]][31:0] = s.ret_data[31:0];   // Odd is the low word
         end else if (in.op == ffu_pkg::op_fld) begin
            model_frf[in.tid][in.rd[4:1]][63:32] = s.ret_data[31:0];
         end else if (in.op == ffu_pkg::op_ldfsr) begin
            model_fsr[in.tid] = s.ret_data[31:0] & 32'hCF80_0FFF;     // Reserved fields clear
         end else if (s.fcmp) begin
            model_fsr[in.tid][11:10] = s.fcc;
         end else begin
            model_frf[in.tid][in.rd[4:1]] = s.ret_data;
            model_fsr[in.tid][4:0]        = s.exc;
            model_fsr[in.tid][9:5]        = model_fsr[in.tid][9:5] | s.exc;
         end
      end
      repeat (3) @(posedge rclk);               // VIS write-back lands before the next read
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////
   initial begin
      rst           = 1'b1;
      inst_vld      = 1'b0;
      inst          = '0;
      ld_vld        = 1'b0;
      ld_tid        = '0;
      ld_data       = '0;
      cpx_vld       = 1'b0;
      cpx           = '0;
      lcg_state     = 32'h9666;
      timed_out     = 1'b0;
      timing_errors = 0;
      for (int t = 0; t < `FFU_NUM_THREADS; t++) begin
         model_fsr[t] = '0;
      end
      build_table();
      repeat (4) @(posedge rclk);
      #2;
      rst = 1'b0;
      repeat (6) @(posedge rclk);               // Strobes stay quiet while idle
      for (int i = 0; i < steps.size() && !timed_out; i++) begin
         apply_step(steps[i], names[i]);
      end
      repeat (4) @(posedge rclk);
      checker_inst.report_counts();
      if (!timed_out && timing_errors == 0 && checker_inst.errors == 0 &&
          checker_inst.unmatched_count() == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule
